//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_copro_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/alu_arith.sv
module alu_arith (
  input  logic [alu_pkg::data_width-1:0] a,
  input  logic [alu_pkg::data_width-1:0] b,
  input  alu_pkg::alu_op_e               op,
  output logic [alu_pkg::data_width-1:0] result
);

  import alu_pkg::*;

  logic                  subtract;
  logic [data_width-1:0] b_eff;
  logic [data_width:0]   sum;
  logic                  less_signed;
  logic                  less_unsigned;

  // Compares also subtract
  assign subtract = (op == sub) || (op == slt) || (op == sltu);

  ////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////

  // a - b as a + ~b + 1
  assign b_eff = subtract ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{data_width{1'b0}}, subtract};

  // No carry out means a borrow
  assign less_unsigned = !sum[data_width];

  // Equal signs cannot overflow, so the difference sign decides
  // Different signs, the negative operand is the smaller one
  assign less_signed = (a[data_width-1] != b[data_width-1]) ? a[data_width-1]
                                                             : sum[data_width-1];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (op)
      add, sub: result = sum[data_width-1:0];
      and_op:   result = a & b;
      or_op:    result = a | b;
      xor_op:   result = a ^ b;
      slt:      result = {{(data_width-1){1'b0}}, less_signed};
      sltu:     result = {{(data_width-1){1'b0}}, less_unsigned};
      // Shifts and unused codes
      default:  result = '0;
    endcase
  end

endmodule

//--- hdl/alu_copro_top.sv
module alu_copro_top (
  input  logic               clk,
  input  logic               reset,
  // AXI4-Lite write
  input  logic               aw_valid,
  input  axil_pkg::axil_aw_t aw,
  output logic               aw_ready,
  input  logic               w_valid,
  input  axil_pkg::axil_w_t  w,
  output logic               w_ready,
  output logic               b_valid,
  output axil_pkg::axil_b_t  b,
  input  logic               b_ready,
  // AXI4-Lite read
  input  logic               ar_valid,
  input  axil_pkg::axil_ar_t ar,
  output logic               ar_ready,
  output logic               r_valid,
  output axil_pkg::axil_r_t  r,
  input  logic               r_ready
);

  import alu_pkg::*;

  // Register block to ALU
  logic      req_valid;
  logic      req_ready;
  alu_req_t  req;

  // ALU back to register block
  logic      resp_valid;
  logic      resp_ready;
  alu_resp_t resp;

  alu_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .aw_valid   (aw_valid),
    .aw         (aw),
    .aw_ready   (aw_ready),
    .w_valid    (w_valid),
    .w          (w),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b          (b),
    .b_ready    (b_ready),
    .ar_valid   (ar_valid),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r_valid    (r_valid),
    .r          (r),
    .r_ready    (r_ready),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready)
  );

  alu_unit u_alu (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready)
  );

endmodule

//--- hdl/alu_pkg.sv
package alu_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Datapath and immediate widths
  localparam int data_width  = 32;
  localparam int shift_width = 5;
  localparam int imm_width   = 12;

  // Result FIFO geometry
  localparam int fifo_depth  = 4;
  localparam int ptr_width   = $clog2(fifo_depth);
  // Count has to reach fifo_depth itself
  localparam int count_width = $clog2(fifo_depth + 1);

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    slt    = 4'd5,
    sltu   = 4'd6,
    sll    = 4'd7,
    srl    = 4'd8,
    sra    = 4'd9
  } alu_op_e;

  // Command word as written to CMD
  typedef struct packed {
    logic [imm_width-1:0] imm;      // 31:20
    logic [14:0]          reserved; // 19:5
    logic                 use_imm;  // 4
    alu_op_e              op;       // 3:0
  } alu_cmd_t;

  // One issued operation
  typedef struct packed {
    alu_op_e               op;
    logic                  use_imm;
    logic [imm_width-1:0]  imm;
    logic [data_width-1:0] rs1;
    logic [data_width-1:0] rs2;
  } alu_req_t;

  // One finished result
  typedef struct packed {
    logic [data_width-1:0] result;
    alu_op_e               op;
  } alu_resp_t;

endpackage

//--- hdl/alu_regs.sv
module alu_regs (
  input  logic               clk,
  input  logic               reset,
  // AXI4-Lite write
  input  logic               aw_valid,
  input  axil_pkg::axil_aw_t aw,
  output logic               aw_ready,
  input  logic               w_valid,
  input  axil_pkg::axil_w_t  w,
  output logic               w_ready,
  output logic               b_valid,
  output axil_pkg::axil_b_t  b,
  input  logic               b_ready,
  // AXI4-Lite read
  input  logic               ar_valid,
  input  axil_pkg::axil_ar_t ar,
  output logic               ar_ready,
  output logic               r_valid,
  output axil_pkg::axil_r_t  r,
  input  logic               r_ready,
  // ALU request and response
  output logic               req_valid,
  output alu_pkg::alu_req_t  req,
  input  logic               req_ready,
  input  logic               resp_valid,
  input  alu_pkg::alu_resp_t resp,
  output logic               resp_ready
);

  import alu_pkg::*;
  import axil_pkg::*;

  // Operand registers
  logic [data_width-1:0]      rs1_q;
  logic [data_width-1:0]      rs2_q;

  // Write path
  alu_cmd_t                   cmd_word;
  logic                       wr_is_cmd;
  logic                       full_word;
  logic                       cmd_stall;
  logic                       wr_fire;
  logic                       wr_ok;
  logic                       req_fire;

  // Read path
  logic                       ar_fire;
  logic                       pop;
  logic [axil_data_width-1:0] rd_data;
  logic [1:0]                 rd_resp;
  logic [axil_data_width-1:0] status_word;

  // Result FIFO and credits
  logic [data_width-1:0]      fifo_mem [fifo_depth];
  logic [ptr_width-1:0]       wr_ptr_q;
  logic [ptr_width-1:0]       rd_ptr_q;
  logic [count_width-1:0]     count_q;
  logic [count_width-1:0]     credit_q;
  logic                       fifo_empty;
  logic                       busy;

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////

  assign wr_is_cmd = (aw.addr == reg_cmd);
  assign full_word = (w.strb == '1);

  // Hold off CMD while every credit is taken
  assign cmd_stall = aw_valid && wr_is_cmd && ((credit_q == fifo_depth) || !req_ready);

  // Idle ready is high; a lone AW or W sees ready low
  // so both channels always complete together
  assign aw_ready = !b_valid && !cmd_stall && (w_valid || !aw_valid);
  assign w_ready  = !b_valid && !cmd_stall && (aw_valid || !w_valid);
  assign wr_fire  = aw_valid && w_valid && aw_ready && w_ready;

  // Only full-word writes to writable registers
  always_comb begin
    case (aw.addr)
      reg_rs1, reg_rs2, reg_cmd: wr_ok = full_word;
      default:                   wr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else if (wr_fire && wr_ok) begin
      if (aw.addr == reg_rs1) rs1_q <= w.data;
      if (aw.addr == reg_rs2) rs2_q <= w.data;
    end
  end

  // Write response, held until the host takes it
  always_ff @(posedge clk) begin
    if (reset) begin
      b_valid <= 1'b0;
    end else if (wr_fire) begin
      b_valid <= 1'b1;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b.resp <= wr_ok ? resp_okay : resp_slverr;
    end
  end

  ////////////////////////////////////////
  // Command issue
  ////////////////////////////////////////

  // Offered in the same cycle as the CMD write handshake
  assign cmd_word  = alu_cmd_t'(w.data);
  assign req_valid = wr_fire && wr_is_cmd && full_word;
  assign req_fire  = req_valid && req_ready;

  always_comb begin
    req.op      = cmd_word.op;
    req.use_imm = cmd_word.use_imm;
    req.imm     = cmd_word.imm;
    req.rs1     = rs1_q;
    req.rs2     = rs2_q;
  end

  // Credits cover the FIFO space, so results are never refused
  assign resp_ready = 1'b1;

  ////////////////////////////////////////
  // Result FIFO
  ////////////////////////////////////////

  assign fifo_empty = (count_q == '0);

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (resp_valid) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_valid) begin
      fifo_mem[wr_ptr_q] <= resp.result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else begin
      case ({resp_valid, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // FIFO entries plus operations still in the pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_q <= '0;
    end else begin
      case ({req_fire, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Anything counted but not yet stored is in flight
  assign busy = (credit_q != count_q);

  ////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////

  assign ar_ready = !r_valid;
  assign ar_fire  = ar_valid && ar_ready;
  assign pop      = ar_fire && (ar.addr == reg_result) && !fifo_empty;

  always_comb begin
    status_word                  = '0;
    status_word[count_width-1:0] = count_q;
    status_word[8]               = busy;
  end

  always_comb begin
    rd_data = '0;
    rd_resp = resp_okay;
    case (ar.addr)
      reg_rs1:    rd_data = rs1_q;
      reg_rs2:    rd_data = rs2_q;
      reg_cmd:    rd_data = '0;  // write-only, reads as zero
      reg_result: begin
        if (fifo_empty) begin
          rd_resp = resp_slverr;
        end else begin
          rd_data = fifo_mem[rd_ptr_q];
        end
      end
      reg_status: rd_data = status_word;
      default:    rd_resp = resp_slverr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      r_valid <= 1'b0;
    end else if (ar_fire) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // Captured at the address handshake, steady while stalled
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r.data <= rd_data;
      r.resp <= rd_resp;
    end
  end

endmodule

//--- hdl/alu_shift.sv
module alu_shift (
  input  logic [alu_pkg::data_width-1:0]  operand,
  input  logic [alu_pkg::shift_width-1:0] amount,
  input  alu_pkg::alu_op_e                op,
  output logic [alu_pkg::data_width-1:0]  result
);

  import alu_pkg::*;

  logic                  shift_right;
  logic                  fill;
  logic [data_width-1:0] mirrored_in;
  // Entry 0 is the ladder input, last entry the output
  logic [data_width-1:0] ladder [shift_width+1];

  ////////////////////////////////////////
  // Direction and fill
  ////////////////////////////////////////

  // Right shifts run through the left ladder mirrored
  assign shift_right = (op == srl) || (op == sra);

  // Sign fill for sra only
  // lands on the high bits once mirrored back
  assign fill = (op == sra) && operand[data_width-1];

  ////////////////////////////////////////
  // Mirror in and out
  ////////////////////////////////////////

  for (genvar j = 0; j < data_width; j++) begin : g_mirror
    assign mirrored_in[j] = shift_right ? operand[data_width-1-j] : operand[j];
    assign result[j]      = shift_right ? ladder[shift_width][data_width-1-j]
                                        : ladder[shift_width][j];
  end

  ////////////////////////////////////////
  // Left-shift ladder
  ////////////////////////////////////////

  assign ladder[0] = mirrored_in;

  // Level i shifts by 2**i when its amount bit is set
  for (genvar i = 0; i < shift_width; i++) begin : g_ladder
    assign ladder[i+1] = amount[i]
                       ? {ladder[i][data_width-1-(2**i):0], {(2**i){fill}}}
                       : ladder[i];
  end

endmodule

//--- hdl/alu_unit.sv
module alu_unit (
  input  logic               clk,
  input  logic               reset,
  // Request side
  input  logic               req_valid,
  input  alu_pkg::alu_req_t  req,
  output logic               req_ready,
  // Response side
  output logic               resp_valid,
  output alu_pkg::alu_resp_t resp,
  input  logic               resp_ready
);

  import alu_pkg::*;

  // Request stage output
  alu_req_t              req_q;
  logic                  req_q_valid;
  logic                  req_q_ready;

  // Operands and results
  logic [data_width-1:0] imm_ext;
  logic [data_width-1:0] operand_b;
  logic [data_width-1:0] shift_result;
  logic [data_width-1:0] arith_result;
  logic                  is_shift;
  alu_resp_t             resp_d;

  ////////////////////////////////////////
  // Stage 1 request register
  ////////////////////////////////////////

  pipe_reg #(.payload_t(alu_req_t)) u_req_stage (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_data   (req),
    .in_ready  (req_ready),
    .out_valid (req_q_valid),
    .out_data  (req_q),
    .out_ready (req_q_ready)
  );

  // Sign-extended immediate or rs2
  assign imm_ext   = {{(data_width-imm_width){req_q.imm[imm_width-1]}}, req_q.imm};
  assign operand_b = req_q.use_imm ? imm_ext : req_q.rs2;

  // Shift amount is the low bits of operand b
  alu_shift u_shift (
    .operand (req_q.rs1),
    .amount  (operand_b[shift_width-1:0]),
    .op      (req_q.op),
    .result  (shift_result)
  );

  alu_arith u_arith (
    .a      (req_q.rs1),
    .b      (operand_b),
    .op     (req_q.op),
    .result (arith_result)
  );

  assign is_shift = (req_q.op == sll) || (req_q.op == srl) || (req_q.op == sra);

  always_comb begin
    resp_d.op     = req_q.op;
    resp_d.result = is_shift ? shift_result : arith_result;
  end

  ////////////////////////////////////////
  // Stage 2 response register
  ////////////////////////////////////////

  pipe_reg #(.payload_t(alu_resp_t)) u_resp_stage (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req_q_valid),
    .in_data   (resp_d),
    .in_ready  (req_q_ready),
    .out_valid (resp_valid),
    .out_data  (resp),
    .out_ready (resp_ready)
  );

endmodule

//--- hdl/axil_pkg.sv
package axil_pkg;

  // Bus widths
  localparam int axil_addr_width = 5;
  localparam int axil_data_width = 32;
  localparam int axil_strb_width = axil_data_width / 8;

  // Response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [axil_addr_width-1:0] reg_rs1    = 5'h00;
  localparam logic [axil_addr_width-1:0] reg_rs2    = 5'h04;
  localparam logic [axil_addr_width-1:0] reg_cmd    = 5'h08;
  localparam logic [axil_addr_width-1:0] reg_result = 5'h0C;
  localparam logic [axil_addr_width-1:0] reg_status = 5'h10;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  // Valid and ready are separate ports
  typedef struct packed {
    logic [axil_addr_width-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [axil_data_width-1:0] data;
    logic [axil_strb_width-1:0] strb;  // Must be all ones to take effect
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [axil_addr_width-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [axil_data_width-1:0] data;
    logic [1:0]                 resp;
  } axil_r_t;

endpackage

//--- hdl/pipe_reg.sv
module pipe_reg #(
  parameter type payload_t = alu_pkg::alu_req_t
) (
  input  logic     clk,
  input  logic     reset,
  // Upstream side
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  // Downstream side
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // Free when empty or when the held entry leaves this cycle
  assign in_ready = !out_valid || out_ready;

  // Occupancy flag
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Payload only moves on a real transfer
  // so a stalled output keeps its value
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

//--- sources.f
hdl/alu_pkg.sv
hdl/axil_pkg.sv
hdl/pipe_reg.sv
hdl/alu_shift.sv
hdl/alu_arith.sv
hdl/alu_unit.sv
hdl/alu_regs.sv
hdl/alu_copro_top.sv
test/alu_regs_props.sv
test/alu_copro_tb.sv

//--- test/alu_cases.txt
// Columns: op use_imm imm rs1 rs2 expected, all hex
// A row with op f ends the list
0 0 000 00000005 00000007 0000000c
0 1 fff 00000010 00000000 0000000f
1 0 000 00000003 00000005 fffffffe
2 0 000 f0f0ff00 0ff0f0f0 00f0f000
3 1 0a5 12340000 00000000 123400a5
4 0 000 aaaa5555 ffff0000 55555555
5 0 000 ffffffff 00000001 00000001
6 0 000 ffffffff 00000001 00000000
5 1 800 00000000 00000000 00000000
7 0 000 12345678 00000000 12345678
7 1 01f 00000003 00000000 80000000
8 0 000 80000000 0000001f 00000001
8 1 024 f0000000 00000000 0f000000
9 0 000 f0000000 00000004 ff000000
9 1 01f 80000000 00000000 ffffffff
f 0 000 00000000 00000000 00000000

//--- test/alu_copro_tb.sv
module alu_copro_tb;

  import alu_pkg::*;
  import axil_pkg::*;

  localparam int max_cases  = 32;
  localparam int n_random   = 32;
  // Weight of the non-table tests in the timeout budget
  localparam int n_extra    = 8;

  logic               clk;
  logic               reset;
  logic               aw_valid;
  axil_aw_t           aw;
  logic               aw_ready;
  logic               w_valid;
  axil_w_t            w;
  logic               w_ready;
  logic               b_valid;
  axil_b_t            b;
  logic               b_ready;
  logic               ar_valid;
  axil_ar_t           ar;
  logic               ar_ready;
  logic               r_valid;
  axil_r_t            r;
  logic               r_ready;

  // Six words per case, see the data file
  logic [31:0]        case_mem [6*max_cases];
  logic [31:0]        lfsr_q;
  int                 n_directed;
  int                 errors;
  int                 errs_at_start;
  int                 tests_passed;
  int                 tests_failed;
  int                 cycles;
  int                 cycle_limit = 200;

  alu_copro_top dut (
    .clk      (clk),
    .reset    (reset),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog on total cycles
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checks and bookkeeping
  ////////////////////////////////////////

  task automatic report_problem(input string what);
    $display("Error at time %0t: %s", $time, what);
    errors++;
  endtask

  task automatic check_data(input string name, input logic [data_width-1:0] got,
                            input logic [data_width-1:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [count_width-1:0] got,
                             input logic [count_width-1:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic begin_test();
    errs_at_start = errors;
  endtask

  // One line per finished test
  task automatic end_test(input string name);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus sources and model
  ////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Expected result from the operation rules
  function automatic logic [31:0] expected_result(input alu_op_e op, input logic use_imm,
                                                  input logic [11:0] imm,
                                                  input logic [31:0] rs1,
                                                  input logic [31:0] rs2);
    logic [31:0] opb;
    opb = use_imm ? {{20{imm[11]}}, imm} : rs2;
    case (op)
      add:     return rs1 + opb;
      sub:     return rs1 - opb;
      and_op:  return rs1 & opb;
      or_op:   return rs1 | opb;
      xor_op:  return rs1 ^ opb;
      slt:     return ($signed(rs1) < $signed(opb)) ? 32'd1 : 32'd0;
      sltu:    return (rs1 < opb) ? 32'd1 : 32'd0;
      sll:     return rs1 << opb[4:0];
      srl:     return rs1 >> opb[4:0];
      sra:     return $signed(rs1) >>> opb[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] cmd_word(input alu_op_e op, input logic use_imm,
                                           input logic [11:0] imm);
    alu_cmd_t c;
    c         = '0;
    c.op      = op;
    c.use_imm = use_imm;
    c.imm     = imm;
    return c;
  endfunction

  ////////////////////////////////////////
  // AXI4-Lite host tasks
  ////////////////////////////////////////

  // Entered just after a rising edge; hold keeps BREADY low that many cycles
  task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                            input int hold, output logic [1:0] resp);
    axil_b_t first;
    aw_valid <= 1'b1;
    aw.addr  <= addr;
    w_valid  <= 1'b1;
    w.data   <= data;
    w.strb   <= '1;
    b_ready  <= 1'b0;
    @(posedge clk);
    while (!(aw_ready && w_ready)) @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    @(posedge clk);
    while (!b_valid) @(posedge clk);
    first = b;
    repeat (hold) begin
      @(posedge clk);
      if (!b_valid || b !== first) begin
        report_problem("write response dropped or changed while BREADY was low");
      end
    end
    b_ready <= 1'b1;
    @(posedge clk);
    resp    = b.resp;
    b_ready <= 1'b0;
  endtask

  task automatic axil_read(input logic [4:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    axil_r_t first;
    ar_valid <= 1'b1;
    ar.addr  <= addr;
    r_ready  <= 1'b0;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    ar_valid <= 1'b0;
    @(posedge clk);
    while (!r_valid) @(posedge clk);
    first = r;
    repeat (hold) begin
      @(posedge clk);
      if (!r_valid || r !== first) begin
        report_problem("read response dropped or changed while RREADY was low");
      end
    end
    r_ready <= 1'b1;
    @(posedge clk);
    data    = r.data;
    resp    = r.resp;
    r_ready <= 1'b0;
  endtask

  // Poll STATUS until the pipeline has drained
  task automatic wait_idle();
    logic [31:0] data;
    logic [1:0]  resp;
    data = 32'h100;
    while (data[8]) begin
      axil_read(reg_status, 0, data, resp);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_case(input string name, input alu_op_e op, input logic use_imm,
                          input logic [11:0] imm, input logic [31:0] rs1,
                          input logic [31:0] rs2, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    begin_test();
    axil_write(reg_rs1, rs1, 0, resp);
    check_resp("b.resp", resp, resp_okay);
    axil_write(reg_rs2, rs2, 0, resp);
    check_resp("b.resp", resp, resp_okay);
    axil_write(reg_cmd, cmd_word(op, use_imm, imm), 0, resp);
    check_resp("b.resp", resp, resp_okay);
    wait_idle();
    axil_read(reg_result, 0, data, resp);
    check_resp("r.resp", resp, resp_okay);
    check_data("r.data", data, exp);
    end_test(name);
  endtask

  task automatic test_after_reset();
    logic [31:0] data;
    logic [1:0]  resp;
    begin_test();
    axil_read(reg_status, 0, data, resp);
    check_count("status count", data[count_width-1:0], '0);
    if (data[8]) report_problem("STATUS busy set right after reset");
    axil_read(reg_result, 0, data, resp);
    check_resp("r.resp", resp, resp_slverr);
    end_test("after_reset");
  endtask

  // Fill the FIFO, then a fifth CMD has to wait for a RESULT pop
  task automatic test_fifo_full();
    logic [31:0] expect_q [$];
    logic [31:0] data;
    logic [1:0]  resp;
    logic [1:0]  fifth_resp;
    logic        fifth_done;
    alu_op_e     ops [4] = '{add, sub, xor_op, or_op};
    begin_test();
    fifth_done = 1'b0;
    axil_write(reg_rs1, 32'h0000_1000, 0, resp);
    axil_write(reg_rs2, 32'h0000_0234, 0, resp);
    for (int k = 0; k < 4; k++) begin
      axil_write(reg_cmd, cmd_word(ops[k], k[0], 12'(k + 1)), 0, resp);
      check_resp("b.resp", resp, resp_okay);
      expect_q.push_back(expected_result(ops[k], k[0], 12'(k + 1),
                                         32'h0000_1000, 32'h0000_0234));
    end
    expect_q.push_back(expected_result(add, 1'b1, 12'h7ff, 32'h0000_1000, 32'h0));
    wait_idle();
    axil_read(reg_status, 0, data, resp);
    check_count("status count", data[count_width-1:0], count_width'(4));
    fork
      begin
        axil_write(reg_cmd, cmd_word(add, 1'b1, 12'h7ff), 0, fifth_resp);
        fifth_done = 1'b1;
      end
      begin
        repeat (10) @(posedge clk);
        if (fifth_done) report_problem("fifth CMD write completed with the FIFO full");
        axil_read(reg_result, 0, data, resp);
        check_resp("r.resp", resp, resp_okay);
        check_data("r.data", data, expect_q.pop_front());
      end
    join
    check_resp("b.resp", fifth_resp, resp_okay);
    wait_idle();
    // Remaining results in issue order
    while (expect_q.size() > 0) begin
      axil_read(reg_result, 0, data, resp);
      check_resp("r.resp", resp, resp_okay);
      check_data("r.data", data, expect_q.pop_front());
    end
    end_test("fifo_full");
  endtask

  task automatic test_bus_errors();
    logic [31:0] data;
    logic [1:0]  resp;
    begin_test();
    axil_read(reg_result, 0, data, resp);
    check_resp("r.resp", resp, resp_slverr);
    check_data("r.data", data, '0);
    axil_write(reg_status, 32'h1234_5678, 0, resp);
    check_resp("b.resp", resp, resp_slverr);
    axil_read(5'h1C, 0, data, resp);
    check_resp("r.resp", resp, resp_slverr);
    end_test("bus_errors");
  endtask

  task automatic test_slow_host();
    logic [31:0] data;
    logic [1:0]  resp;
    begin_test();
    axil_write(reg_rs1, 32'hcafe_0042, 6, resp);
    check_resp("b.resp", resp, resp_okay);
    axil_read(reg_rs1, 6, data, resp);
    check_resp("r.resp", resp, resp_okay);
    check_data("r.data", data, 32'hcafe_0042);
    end_test("slow_host");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    alu_op_e     op;
    logic [31:0] op_bits;
    logic        use_imm;
    logic [11:0] imm;
    logic [31:0] rs1;
    logic [31:0] rs2;
    reset      = 1'b1;
    aw_valid   = 1'b0;
    aw         = '0;
    w_valid    = 1'b0;
    w          = '0;
    b_ready    = 1'b0;
    ar_valid   = 1'b0;
    ar         = '0;
    r_ready    = 1'b0;
    errors     = 0;
    cycles     = 0;
    lfsr_q     = 32'hed4a8638;
    n_directed = 0;
    $readmemh("test/alu_cases.txt", case_mem);
    // Op code f marks the end of the table
    while (n_directed < max_cases && case_mem[6*n_directed][3:0] != 4'hf) begin
      n_directed++;
    end
    cycle_limit = 40 * (n_directed + n_random + n_extra) + 200;

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    test_after_reset();
    for (int i = 0; i < n_directed; i++) begin
      op = alu_op_e'(case_mem[6*i][3:0]);
      run_case($sformatf("case_%0d_%s", i, op.name()), op, case_mem[6*i+1][0],
               case_mem[6*i+2][11:0], case_mem[6*i+3], case_mem[6*i+4],
               case_mem[6*i+5]);
    end
    for (int i = 0; i < n_random; i++) begin
      op_bits = take_bits(4) % 10;
      op      = alu_op_e'(op_bits[3:0]);
      use_imm = take_bits(1) != 0;
      imm     = take_bits(12);
      rs1     = take_bits(32);
      rs2     = take_bits(32);
      run_case($sformatf("random_%0d_%s", i, op.name()), op, use_imm, imm, rs1, rs2,
               expected_result(op, use_imm, imm, rs1, rs2));
    end
    test_fifo_full();
    test_bus_errors();
    test_slow_host();

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- test/alu_regs_props.sv
module alu_regs_props (
  input logic                            clk,
  input logic                            reset,
  input logic                            b_valid,
  input logic                            b_ready,
  input axil_pkg::axil_b_t               b,
  input logic                            r_valid,
  input logic                            r_ready,
  input axil_pkg::axil_r_t               r,
  input logic                            req_valid,
  input logic                            req_ready,
  input logic [alu_pkg::count_width-1:0] credit_q
);

  import alu_pkg::*;

  ////////////////////////////////////////
  // Response channels
  ////////////////////////////////////////

  // Write response held with steady payload until taken
  a_b_hold : assert property (@(posedge clk) disable iff (reset)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("BVALID dropped or payload changed before BREADY");

  // Same rule on the read data channel
  a_r_hold : assert property (@(posedge clk) disable iff (reset)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("RVALID dropped or payload changed before RREADY");

  ////////////////////////////////////////
  // ALU request side
  ////////////////////////////////////////

  a_req_hold : assert property (@(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid)
    else $error("req_valid dropped before req_ready");

  // FIFO plus in-flight never above the FIFO size
  a_credit_max : assert property (@(posedge clk) disable iff (reset)
    credit_q <= count_width'(fifo_depth))
    else $error("credit count above FIFO depth");

endmodule

bind alu_regs alu_regs_props u_props (.*);
